//--- design/fdc_pkg.sv
`default_nettype none

package fdc_pkg;

	// --------------------------------------------------
	// widths with a meaning
	// --------------------------------------------------
	typedef logic [7:0]  byte_t;       // register or data byte
	typedef logic [1:0]  reg_addr_t;   // host register select
	typedef logic [19:0] buff_addr_t;  // sector buffer RAM address
	typedef logic [9:0]  byte_idx_t;   // byte inside a sector, up to 1024
	typedef logic [2:0]  size_code_t;  // geometry select, 0..4
	typedef logic [11:0] delay_t;      // timer count
	typedef logic [3:0]  shift_t;      // log2 of sector length

	// host register map
	localparam reg_addr_t A_CMD_STAT = 2'd0;  // command on write, status on read
	localparam reg_addr_t A_TRACK    = 2'd1;
	localparam reg_addr_t A_SECTOR   = 2'd2;
	localparam reg_addr_t A_DATA     = 2'd3;

	// upper nibble of the command byte
	localparam logic [3:0] CMD_RESTORE   = 4'h0;
	localparam logic [3:0] CMD_SEEK      = 4'h1;
	localparam logic [3:0] CMD_READ      = 4'h8;  // 8 and 9
	localparam logic [3:0] CMD_WRITE     = 4'hA;  // A and B
	localparam logic [3:0] CMD_FORCE_INT = 4'hD;
	// step family is 2..7, anything above B except D is dropped

	// --------------------------------------------------
	// delays, in clk_sys cycles
	// --------------------------------------------------
	localparam delay_t SETTLE_CYCLES = 12'd64;  // type I busy time
	localparam delay_t SEEK_CYCLES   = 12'd32;  // before first data byte
	localparam delay_t DRQ_CYCLES    = 12'd4;   // buffer fetch to DRQ

	// geometry tables, indexed by size code
	//  0: 26 x 128   1: 16 x 256   2: 9 x 512   3: 5 x 1024   4: 10 x 512
	localparam size_code_t SIZE_CODE_MAX = 3'd4;
	localparam byte_t  SPT [5]        = '{8'd26, 8'd16, 8'd9, 8'd5, 8'd10};
	localparam shift_t SIZE_SHIFT [5] = '{4'd7, 4'd8, 4'd9, 4'd10, 4'd9};

	// sequencer FSM
	typedef enum logic [3:0] {
		IDLE,
		SETTLE,     // type I busy period
		SEEK_WAIT,  // head travel before a transfer
		RD_FETCH,   // buffer read strobe
		RD_DELAY,
		RD_DRQ,     // byte waiting for host
		WR_DRQ,     // waiting for host byte
		WR_NEXT,
		FINISH      // drop busy, raise intrq
	} seq_state_t;

endpackage

`default_nettype wire

//--- design/fdc_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// register file <-> command sequencer
interface fdc_cmd_if import fdc_pkg::*; ();

	// from the register file
	byte_t command;     // latched command byte
	logic  cmd_valid;   // command pending, not yet taken
	byte_t track_reg;
	byte_t sector_reg;
	byte_t data_reg;
	logic  force_int;   // single cycle, D nibble written

	// from the sequencer
	logic  cmd_take;    // pending cleared
	logic  track_load;
	byte_t track_value;
	logic  busy;
	logic  drq;
	logic  cmd_done;    // sets intrq
	logic  head_loaded;
	logic  seek_err;
	logic  crc_err;
	logic  wr_fault;
	logic  track0;
	logic  type2;       // status layout select
	logic  xfer_read;
	logic  xfer_write;

	modport regs (
		output command, cmd_valid, track_reg, sector_reg, data_reg, force_int,
		input  cmd_take, track_load, track_value, busy, drq, cmd_done,
		input  head_loaded, seek_err, crc_err, wr_fault, track0, type2,
		input  xfer_read, xfer_write
	);

	modport seq (
		input  command, cmd_valid, track_reg, sector_reg, data_reg, force_int,
		output cmd_take, track_load, track_value, busy, drq, cmd_done,
		output head_loaded, seek_err, crc_err, wr_fault, track0, type2,
		output xfer_read, xfer_write
	);

endinterface

`default_nettype wire

//--- design/fdc_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_host_regs import fdc_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      io_en,
	input  logic      rd,
	input  logic      wr,
	input  reg_addr_t addr,
	input  byte_t     din,
	output byte_t     dout,
	input  byte_t     buff_din,
	input  logic      ready,
	output logic      intrq,
	output logic      buff_write,
	output byte_t     buff_dout,
	output logic      data_ack,
	fdc_cmd_if.regs   cmd
);

	logic  rd_s;        // qualified strobes
	logic  wr_s;
	logic  rd_data;
	logic  wr_data;
	logic  busy_flag;   // running or pending
	logic  cmd_accept;
	byte_t status;

	assign rd_s = rd & io_en;
	assign wr_s = wr & io_en;
	assign rd_data = rd_s && (addr == A_DATA);
	assign wr_data = wr_s && (addr == A_DATA);
	assign busy_flag = cmd.busy | cmd.cmd_valid;

	// --------------------------------------------------
	// command decode
	// --------------------------------------------------
	assign cmd.force_int = wr_s && (addr == A_CMD_STAT) && (din[7:4] == CMD_FORCE_INT);
	// 0..B only, C/E/F dropped silently
	assign cmd_accept = wr_s && (addr == A_CMD_STAT) && !busy_flag &&
		(din[7:4] <= {CMD_WRITE[3:1], 1'b1});

	// DRQ handshake, read byte out or write byte in
	assign data_ack = cmd.drq && (cmd.xfer_read ? rd_data : wr_data);
	assign buff_write = wr_data && cmd.drq && !cmd.xfer_read;
	assign buff_dout = din;  // host byte goes straight to RAM

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cmd.command <= '0;
			cmd.cmd_valid <= 1'b0;
			cmd.track_reg <= '0;
			cmd.sector_reg <= '0;
			cmd.data_reg <= '0;
			intrq <= 1'b0;
		end else begin
			if (cmd.cmd_take || cmd.force_int)
				cmd.cmd_valid <= 1'b0;
			if (rd_s && (addr == A_CMD_STAT))
				intrq <= 1'b0;          // status read acks irq

			if (wr_s) begin
				case (addr)
					A_CMD_STAT: begin
						intrq <= 1'b0;  // any command write
						if (cmd_accept) begin
							cmd.command <= din;
							cmd.cmd_valid <= 1'b1;
						end
					end
					A_TRACK:  if (!cmd.busy) cmd.track_reg <= din;
					A_SECTOR: if (!cmd.busy) cmd.sector_reg <= din;
					default:  cmd.data_reg <= din;
				endcase
			end

			if (cmd.track_load)
				cmd.track_reg <= cmd.track_value;  // restore / step with update
			if (cmd.cmd_done)
				intrq <= 1'b1;     // wins over the clears above
		end
	end

	// --------------------------------------------------
	// status and read mux
	// --------------------------------------------------
	// bit 6 write protect never set, index and lost data read 0
	assign status = cmd.type2 ?
		{~ready, 1'b0, cmd.wr_fault, cmd.seek_err, cmd.crc_err, 1'b0, cmd.drq, busy_flag} :
		{~ready, 1'b0, cmd.head_loaded, cmd.seek_err, cmd.crc_err, cmd.track0, 1'b0, busy_flag};

	always_comb begin
		case (addr)
			A_CMD_STAT: dout = status;
			A_TRACK:    dout = cmd.track_reg;
			A_SECTOR:   dout = cmd.sector_reg;
			default:    dout = cmd.xfer_read ? buff_din : cmd.data_reg;
		endcase
	end

	// RAM writes only come out of a write sector transfer
	a_buff_write: assert property (@(posedge clk_sys) disable iff (reset)
		buff_write |-> cmd.xfer_write)
		else $error("buffer write outside write transfer");

endmodule

`default_nettype wire

//--- design/fdc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_sequencer import fdc_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      ready,
	input  logic      data_ack,
	fdc_cmd_if.seq    cmd,
	output logic      timer_load,
	output delay_t    timer_count,
	input  logic      timer_expired,
	output byte_t     cur_track,
	output byte_idx_t byte_idx,
	input  logic      last_byte,
	output logic      buff_read
);

	seq_state_t state;
	logic       step_dir;    // last direction, 0 = in
	logic       wr_cmd;      // type II is a write
	logic [3:0] op;
	logic       dir_now;
	byte_t      next_track;

	assign op = cmd.command[7:4];
	// bit 6 set: direction given by bit 5
	assign dir_now = cmd.command[6] ? cmd.command[5] : step_dir;
	assign next_track = dir_now ? cur_track - 8'd1 : cur_track + 8'd1;

	assign cmd.cmd_take = (state == IDLE) && cmd.cmd_valid && !cmd.force_int;
	assign cmd.cmd_done = (state == FINISH);
	assign cmd.xfer_read = (state == RD_FETCH) || (state == RD_DELAY) || (state == RD_DRQ);
	assign cmd.xfer_write = (state == WR_DRQ) || (state == WR_NEXT);
	assign cmd.track0 = (cur_track == 8'd0);
	assign buff_read = (state == RD_FETCH);  // RAM data one cycle later

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			step_dir <= 1'b0;
			wr_cmd <= 1'b0;
			cur_track <= '0;
			byte_idx <= '0;
			timer_load <= 1'b0;
			timer_count <= '0;
			cmd.track_load <= 1'b0;
			cmd.track_value <= '0;
			cmd.busy <= 1'b0;
			cmd.drq <= 1'b0;
			cmd.type2 <= 1'b0;
			{cmd.head_loaded, cmd.seek_err, cmd.crc_err, cmd.wr_fault} <= '0;
		end else begin
			timer_load <= 1'b0;      // pulses
			cmd.track_load <= 1'b0;

			if (cmd.force_int && state == IDLE) begin
				// nothing running, just wipe the errors
				{cmd.seek_err, cmd.crc_err, cmd.wr_fault} <= '0;
				cmd.type2 <= 1'b0;
			end else if (cmd.force_int && state != FINISH) begin
				cmd.drq <= 1'b0;
				cmd.type2 <= 1'b0;
				timer_load <= 1'b1;   // zero count stops the timer
				timer_count <= '0;
				state <= FINISH;
			end else begin
				case (state)
					IDLE: begin
						if (cmd.cmd_valid) begin
							cmd.busy <= 1'b1;
							cmd.type2 <= op[3];
							timer_load <= 1'b1;
							if (op[3]) begin
								// read / write sector
								{cmd.seek_err, cmd.crc_err, cmd.wr_fault} <= '0;
								wr_cmd <= (op[3:1] != CMD_READ[3:1]);
								timer_count <= SEEK_CYCLES;
								state <= SEEK_WAIT;
							end else begin
								cmd.head_loaded <= cmd.command[3];
								timer_count <= SETTLE_CYCLES;
								state <= SETTLE;
								if (op == CMD_RESTORE) begin
									cur_track <= '0;
									cmd.track_value <= '0;
									cmd.track_load <= 1'b1;
								end else if (op == CMD_SEEK) begin
									cur_track <= cmd.data_reg;   // head only
								end else begin
									// step, step-in, step-out
									if (cmd.command[6])
										step_dir <= cmd.command[5];
									cur_track <= next_track;
									cmd.track_value <= next_track;
									cmd.track_load <= cmd.command[4];  // update flag
								end
							end
						end
					end
					SETTLE: if (timer_expired) state <= FINISH;
					SEEK_WAIT: begin
						if (timer_expired) begin
							byte_idx <= '0;
							if (wr_cmd) begin
								cmd.drq <= 1'b1;  // ask for first byte
								state <= WR_DRQ;
							end else if (!ready) begin
								cmd.seek_err <= 1'b1;   // no disk
								cmd.crc_err <= 1'b1;
								state <= FINISH;
							end else begin
								timer_load <= 1'b1;
								timer_count <= DRQ_CYCLES;
								state <= RD_FETCH;
							end
						end
					end
					RD_FETCH: state <= RD_DELAY;
					RD_DELAY: begin
						if (timer_expired) begin
							cmd.drq <= 1'b1;
							state <= RD_DRQ;
						end
					end
					RD_DRQ: begin
						if (data_ack) begin
							cmd.drq <= 1'b0;
							if (last_byte) begin
								state <= FINISH;
							end else begin
								byte_idx <= byte_idx + 10'd1;
								timer_load <= 1'b1;
								timer_count <= DRQ_CYCLES;
								state <= RD_FETCH;
							end
						end
					end
					WR_DRQ: begin
						if (data_ack) begin
							cmd.drq <= 1'b0;  // byte already in RAM
							state <= WR_NEXT;
						end
					end
					WR_NEXT: begin
						if (last_byte) begin
							cmd.wr_fault <= !ready;  // disk gone by sector end
							state <= FINISH;
						end else begin
							byte_idx <= byte_idx + 10'd1;
							cmd.drq <= 1'b1;
							state <= WR_DRQ;
						end
					end
					default: begin
						// FINISH, intrq rises with this edge
						cmd.busy <= 1'b0;
						cmd.drq <= 1'b0;
						state <= IDLE;
					end
				endcase
			end
		end
	end

	a_drq_busy: assert property (@(posedge clk_sys) disable iff (reset)
		cmd.drq |-> cmd.busy)
		else $error("drq without busy");

	// fetches only belong to a running read sector command
	a_fetch: assert property (@(posedge clk_sys) disable iff (reset)
		buff_read |-> cmd.busy && cmd.type2 && !wr_cmd)
		else $error("buffer read outside read command");

endmodule

`default_nettype wire

//--- design/fdc_delay_timer.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_delay_timer import fdc_pkg::*; (
	input  logic   clk_sys,
	input  logic   reset,
	input  logic   load,
	input  delay_t count,
	output logic   expired
);

	delay_t cnt;
	logic   running;

	// count cycles after load, a zero load just stops it
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cnt <= '0;
			running <= 1'b0;
		end else if (load) begin
			cnt <= count;
			running <= (count != '0);
		end else if (running) begin
			cnt <= cnt - 12'd1;
			if (cnt == 12'd1)
				running <= 1'b0;
		end
	end

	assign expired = running && (cnt == 12'd1);  // single cycle

	a_no_reload: assert property (@(posedge clk_sys) disable iff (reset)
		load && (count != '0) |-> !running)
		else $error("timer loaded while counting");

endmodule

`default_nettype wire

//--- design/fdc_buffer_map.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_buffer_map import fdc_pkg::*; (
	input  size_code_t size_code,
	input  byte_t      cur_track,
	input  byte_t      sector_reg,
	input  logic       side,
	input  byte_idx_t  byte_idx,
	output buff_addr_t buff_addr,
	output logic       last_byte
);

	size_code_t geo;         // clamped size code
	byte_t      spt;
	shift_t     shift;
	buff_addr_t lin_sector;  // sector number inside the image
	byte_idx_t  last_idx;

	// codes above 4 fall back to 10 x 512
	assign geo = (size_code > SIZE_CODE_MAX) ? SIZE_CODE_MAX : size_code;
	assign spt = SPT[geo];
	assign shift = SIZE_SHIFT[geo];

	// --------------------------------------------------
	// image layout: track, then side, then sector
	// --------------------------------------------------
	// sectors count from 1
	assign lin_sector = buff_addr_t'({cur_track, side}) * buff_addr_t'(spt)
		+ buff_addr_t'(sector_reg) - 20'd1;
	assign buff_addr = (lin_sector << shift) + buff_addr_t'(byte_idx);

	// sector length minus one, 1024 still fits
	assign last_idx = byte_idx_t'((11'd1 << shift) - 11'd1);
	assign last_byte = (byte_idx == last_idx);

endmodule

`default_nettype wire

//--- design/fdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_top import fdc_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       io_en,
	input  logic       rd,
	input  logic       wr,
	input  reg_addr_t  addr,
	input  byte_t      din,
	output byte_t      dout,
	output logic       drq,
	output logic       intrq,
	output logic       busy,
	output buff_addr_t buff_addr,
	output logic       buff_read,
	output logic       buff_write,
	input  byte_t      buff_din,
	output byte_t      buff_dout,
	input  size_code_t size_code,
	input  logic       side,
	input  logic       ready
);

	fdc_cmd_if cmd_bus ();

	logic      data_ack;
	logic      timer_load;
	delay_t    timer_count;
	logic      timer_expired;
	byte_t     cur_track;    // head position
	byte_idx_t byte_idx;
	logic      last_byte;

	assign drq = cmd_bus.drq;
	assign busy = cmd_bus.busy;

	fdc_host_regs i_fdc_host_regs (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_en      (io_en),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.din        (din),
		.dout       (dout),
		.buff_din   (buff_din),
		.ready      (ready),
		.intrq      (intrq),
		.buff_write (buff_write),
		.buff_dout  (buff_dout),
		.data_ack   (data_ack),
		.cmd        (cmd_bus.regs)
	);

	fdc_sequencer i_fdc_sequencer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.ready         (ready),
		.data_ack      (data_ack),
		.cmd           (cmd_bus.seq),
		.timer_load    (timer_load),
		.timer_count   (timer_count),
		.timer_expired (timer_expired),
		.cur_track     (cur_track),
		.byte_idx      (byte_idx),
		.last_byte     (last_byte),
		.buff_read     (buff_read)
	);

	fdc_delay_timer i_fdc_delay_timer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.load    (timer_load),
		.count   (timer_count),
		.expired (timer_expired)
	);

	// head position, not the track register, picks the image track
	fdc_buffer_map i_fdc_buffer_map (
		.size_code  (size_code),
		.cur_track  (cur_track),
		.sector_reg (cmd_bus.sector_reg),
		.side       (side),
		.byte_idx   (byte_idx),
		.buff_addr  (buff_addr),
		.last_byte  (last_byte)
	);

endmodule

`default_nettype wire

//--- verif/fdc_tb_tasks.svh
`default_nettype none

// --------------------------------------------------
// host bus, called and left 2 ns after a rising edge
// --------------------------------------------------
task automatic host_write(input reg_addr_t a, input byte_t d);
	addr = a;
	din = d;
	wr = 1'b1;
	io_en = 1'b1;
	@(posedge clk_sys);   // write lands here
	#2;
	wr = 1'b0;
	io_en = 1'b0;
endtask

task automatic host_read(input reg_addr_t a, output byte_t d);
	addr = a;
	rd = 1'b1;
	io_en = 1'b1;
	#1 d = dout;          // dout follows addr
	@(posedge clk_sys);
	#2;
	rd = 1'b0;
	io_en = 1'b0;
endtask

function automatic logic signal_level(input string name);
	if (name == "busy")
		return busy;
	else if (name == "drq")
		return drq;
	return intrq;
endfunction

// cycles counts the edges waited
task automatic wait_signal(input string name, input logic level, output int cycles);
	cycles = 0;
	while (signal_level(name) !== level && cycles < TIMEOUT_CYCLES) begin
		@(posedge clk_sys);
		#2;
		cycles++;
	end
	if (signal_level(name) !== level) begin
		$display("timeout: %s did not go to %0b within %0d cycles", name, level, cycles);
		$display("Something failed");
		$finish;
	end
endtask

task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
	if (expected !== actual) begin
		$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
		errors++;
		test_errors++;
	end
endtask

// --------------------------------------------------
// disk image geometry and contents
// --------------------------------------------------
function automatic int sector_shift(input logic [2:0] sz);
	case (sz)
		3'd0: return 7;
		3'd1: return 8;
		3'd3: return 10;
		default: return 9;   // codes 2 and 4
	endcase
endfunction

function automatic int sectors_per_track(input logic [2:0] sz);
	case (sz)
		3'd0: return 26;
		3'd1: return 16;
		3'd2: return 9;
		3'd3: return 5;
		default: return 10;
	endcase
endfunction

function automatic int sector_len(input logic [2:0] sz);
	return 1 << sector_shift(sz);
endfunction

// track, then side, then sector, sectors count from 1
function automatic logic [19:0] expect_addr(input byte_t trk, input logic sd,
		input byte_t sec, input logic [2:0] sz, input int idx);
	int lin;
	lin = (int'(trk) * 2 + int'(sd)) * sectors_per_track(sz) + int'(sec) - 1;
	return 20'(lin << sector_shift(sz)) + 20'(idx);
endfunction

function automatic byte_t fill_value(input logic [19:0] a);
	return a[7:0] ^ a[15:8] ^ {4'h0, a[19:16]};
endfunction

function automatic byte_t mem_value(input logic [19:0] a);
	if (mem.exists(a))
		return mem[a];
	return fill_value(a);   // never written
endfunction

function automatic string cmd_name(input byte_t c);
	case (c[7:4])
		4'h0: return "restore";
		4'h1: return "seek";
		4'h8, 4'h9: return "read";
		4'ha, 4'hb: return "write";
		4'hd: return "force_int";
		default: return "step";
	endcase
endfunction

`default_nettype wire

//--- verif/fdc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_tb import fdc_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000;          // per wait loop
	localparam logic [31:0] SEED = 32'hea30_b9e0;
	localparam STIM_FILE = "verif/fdc_stim.txt";
	localparam int TYPE1_CYCLES = 64 + 2;          // settle time plus two, busy to intrq

	logic       clk_sys;
	logic       reset;
	logic       io_en;
	logic       rd;
	logic       wr;
	reg_addr_t  addr;
	byte_t      din;
	byte_t      dout;
	logic       drq;
	logic       intrq;
	logic       busy;
	buff_addr_t buff_addr;
	logic       buff_read;
	logic       buff_write;
	byte_t      buff_din;
	byte_t      buff_dout;
	size_code_t size_code;
	logic       side;
	logic       ready;

	byte_t mem [logic [19:0]];   // sparse disk image
	int    errors;
	int    test_errors;
	int    tests;
	int    drq_rises;
	logic  drq_q;
	byte_t head_pos;             // expected head and track register
	byte_t trk_reg;
	logic  last_dir;             // 0 = in

	always #20 clk_sys = ~clk_sys;

	fdc_top i_fdc_top (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.io_en      (io_en),
		.rd         (rd),
		.wr         (wr),
		.addr       (addr),
		.din        (din),
		.dout       (dout),
		.drq        (drq),
		.intrq      (intrq),
		.busy       (busy),
		.buff_addr  (buff_addr),
		.buff_read  (buff_read),
		.buff_write (buff_write),
		.buff_din   (buff_din),
		.buff_dout  (buff_dout),
		.size_code  (size_code),
		.side       (side),
		.ready      (ready)
	);

	// --------------------------------------------------
	// buffer RAM model and drq edge counter
	// --------------------------------------------------
	always @(posedge clk_sys) begin
		if (buff_read)
			buff_din <= mem_value(buff_addr);   // valid the cycle after
		if (buff_write)
			mem[buff_addr] = buff_dout;
		drq_q <= drq;
		if (drq && !drq_q)
			drq_rises <= drq_rises + 1;
	end

	// type I command, data register loaded first
	task automatic type1_test(input byte_t c, input byte_t trk, input byte_t st,
			input string tname);
		byte_t val;
		int    cyc;
		logic  dir;
		host_write(A_DATA, trk);
		host_write(A_CMD_STAT, c);
		wait_signal("busy", 1'b1, cyc);
		wait_signal("intrq", 1'b1, cyc);
		check_value({tname, " cycles"}, TYPE1_CYCLES, cyc);
		check_value({tname, " busy"}, 0, busy);   // falls with intrq
		case (c[7:4])
			4'h0: begin
				head_pos = 8'd0;
				trk_reg = 8'd0;
			end
			4'h1: head_pos = trk;   // seek moves the head only
			default: begin
				dir = c[6] ? c[5] : last_dir;
				last_dir = dir;
				head_pos = dir ? head_pos - 8'd1 : head_pos + 8'd1;
				if (c[4])
					trk_reg = head_pos;
			end
		endcase
		host_read(A_CMD_STAT, val);
		check_value({tname, " status"}, st, val);
		check_value({tname, " track0"}, (head_pos == 8'd0), val[2]);
		host_read(A_TRACK, val);
		check_value({tname, " track reg"}, trk_reg, val);
	endtask

	// head to the image track before a sector command
	task automatic seek_head(input byte_t trk);
		byte_t val;
		int    cyc;
		host_write(A_DATA, trk);
		host_write(A_CMD_STAT, 8'h18);
		wait_signal("intrq", 1'b1, cyc);
		host_read(A_CMD_STAT, val);
		head_pos = trk;
	endtask

	task automatic sector_test(input byte_t c, input byte_t sec, input logic sd,
			input logic [2:0] sz, input logic rdy, input byte_t st, input string tname);
		byte_t val;
		byte_t data_q [$];
		int    cyc;
		int    n_bytes;
		n_bytes = (c[5] || rdy) ? sector_len(sz) : 0;   // no disk, no read data
		host_write(A_SECTOR, sec);
		drq_rises = 0;
		host_write(A_CMD_STAT, c);
		for (int i = 0; i < n_bytes; i++) begin
			wait_signal("drq", 1'b1, cyc);
			if (c[5]) begin
				data_q.push_back(byte_t'($urandom));
				host_write(A_DATA, data_q[i]);
			end else begin
				host_read(A_DATA, val);
				check_value($sformatf("%s byte %0d", tname, i),
					mem_value(expect_addr(head_pos, sd, sec, sz, i)), val);
			end
		end
		wait_signal("intrq", 1'b1, cyc);
		check_value({tname, " busy"}, 0, busy);
		check_value({tname, " drq count"}, n_bytes, drq_rises);
		foreach (data_q[i])
			check_value($sformatf("%s ram %0d", tname, i), data_q[i],
				mem_value(expect_addr(head_pos, sd, sec, sz, i)));
		host_read(A_CMD_STAT, val);
		check_value({tname, " status"}, st, val);
	endtask

	// abort a read after a few bytes
	task automatic force_test(input byte_t sec, input byte_t st, input string tname);
		byte_t val;
		int    cyc;
		host_write(A_SECTOR, sec);
		host_write(A_CMD_STAT, 8'h88);
		for (int i = 0; i < 3; i++) begin
			wait_signal("drq", 1'b1, cyc);
			host_read(A_DATA, val);
		end
		host_write(A_TRACK, trk_reg + 8'h11);   // dropped, still busy
		host_read(A_TRACK, val);
		check_value({tname, " track reg"}, trk_reg, val);
		host_write(A_CMD_STAT, 8'hd0);
		wait_signal("intrq", 1'b1, cyc);
		check_value({tname, " end within 2"}, 1, cyc <= 2);
		check_value({tname, " busy"}, 0, busy);
		host_read(A_CMD_STAT, val);
		check_value({tname, " status"}, st, val);
		check_value({tname, " intrq clear"}, 0, intrq);
	endtask

	task automatic run_test(input byte_t c, input byte_t trk, input byte_t sec,
			input logic sd, input logic [2:0] sz, input logic rdy, input byte_t st);
		string tname;
		tests++;
		test_errors = 0;
		tname = $sformatf("%0d_%s", tests, cmd_name(c));
		size_code = sz;
		side = sd;
		ready = rdy;
		if (!c[7]) begin
			type1_test(c, trk, st, tname);
		end else begin
			seek_head(trk);
			if (c[7:4] == 4'hd)
				force_test(sec, st, tname);
			else
				sector_test(c, sec, sd, sz, rdy, st, tname);
		end
		$display("test %-14s %s", tname, (test_errors == 0) ? "passed" : "failed");
	endtask

	// --------------------------------------------------
	// reset, then one test per stimulus line
	// --------------------------------------------------
	initial begin
		int         fd;
		int         n_items;
		string      line;
		byte_t      c;
		byte_t      trk;
		byte_t      sec;
		byte_t      st;
		logic       sd;
		logic [2:0] sz;
		logic       rdy;
		void'($urandom(SEED));
		clk_sys = 1'b0;
		reset = 1'b1;
		io_en = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		addr = '0;
		din = '0;
		buff_din = '0;
		size_code = '0;
		side = 1'b0;
		ready = 1'b1;
		drq_q = 1'b0;
		drq_rises = 0;
		errors = 0;
		tests = 0;
		head_pos = '0;
		trk_reg = '0;
		last_dir = 1'b0;
		repeat (10) @(posedge clk_sys);
		#2 reset = 1'b0;   // inputs change 2 ns after the edge from here on
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open stimulus file %s", STIM_FILE);
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == "#")
					continue;
				n_items = $sscanf(line, "%h %h %h %h %h %h %h", c, trk, sec, sd, sz, rdy, st);
				if (n_items != 7) begin
					$display("bad stimulus line: %s", line);
					errors++;
				end else begin
					run_test(c, trk, sec, sd, sz, rdy, st);
				end
			end
			$fclose(fd);
		end
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0 && tests > 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	`include "fdc_tb_tasks.svh"

endmodule

`default_nettype wire

//--- verif/fdc_stim.txt
# cmd trk sec side size ready status, all hex, status as read at the end of the test
# type I: trk goes to the data register; read, write and force: head seeks to trk first
08 00 01 0 0 1 24
58 00 01 0 0 1 20
18 05 01 0 0 1 20
38 00 01 0 0 1 20
88 02 03 0 0 1 00
88 03 01 1 1 1 00
88 04 09 0 2 1 00
88 01 05 1 3 1 00
88 0a 0a 0 4 1 00
a8 02 03 0 0 1 00
88 02 03 0 0 1 00
a8 07 02 1 1 1 00
88 07 02 1 1 1 00
88 03 01 0 2 0 98
a8 03 02 0 2 0 a0
d0 04 02 0 1 1 20

//--- build.f
+incdir+verif
design/fdc_pkg.sv
design/fdc_cmd_if.sv
design/fdc_host_regs.sv
design/fdc_sequencer.sv
design/fdc_delay_timer.sv
design/fdc_buffer_map.sv
design/fdc_top.sv
verif/fdc_tb.sv
